// File: design/sacc_addr_pkg.sv
// stream accelerator address layout
package sacc_addr_pkg;

   // io address and its fields
   localparam int addr_width    = 40;
   localparam int region_width  = 9;
   localparam int dev_width     = 4;
   localparam int reg_off_width = 20;
   localparam int tid_width     = 4;

   localparam int dev_pad_width    = addr_width - region_width - dev_width - reg_off_width;
   localparam int stream_pad_width = addr_width - region_width - tid_width;

   // one io address, read as a device access or as a stream beat
   // region sits on top in both views and picks the view
   typedef union packed {
      struct packed {
         logic [region_width-1:0]  region;
         logic [dev_width-1:0]     dev;
         logic [dev_pad_width-1:0] pad;
         logic [reg_off_width-1:0] reg_off;
      } dev_view;
      struct packed {
         logic [region_width-1:0]     region;
         logic [tid_width-1:0]        beat_tid;
         logic [stream_pad_width-1:0] pad;
      } stream_view;
   } sacc_addr_u;

   // device numbers
   localparam logic [dev_width-1:0] dev_cfg = 4'd1;
   localparam logic [dev_width-1:0] dev_dma = 4'd2;

   // frame control register offsets in device 1
   localparam logic [reg_off_width-1:0] reg_tlv_type = 20'h10000;
   localparam logic [reg_off_width-1:0] reg_tlv_idx  = 20'h10008;

   // tlv pair that closes a frame
   localparam int unsigned tlv_last_type = 4;
   localparam int unsigned tlv_last_idx  = 2;

endpackage

// File: design/sacc_msg_pkg.sv
// io message definitions
package sacc_msg_pkg;

   // payload and size field widths
   localparam int data_width = 64;
   localparam int size_width = 3;

   // uncached memory command types
   typedef enum logic [0:0] {
      mem_rd = 1'b0,
      mem_wr = 1'b1
   } mem_type_e;

   // log2 of the byte count, so 3 means one 64-bit word
   // dma fetches always move a full word
   localparam logic [size_width-1:0] size_8b = 3'd3;

endpackage

// File: design/sacc_cfg_regs.sv
// frame control registers
`timescale 1ns/10ps

module sacc_cfg_regs
   (
      input  logic                                 clk_i
    , input  logic                                 arst_n_i

    , input  logic                                 cfg_we_i
    , input  logic                                 cfg_wsel_i
    , input  logic [sacc_msg_pkg::data_width-1:0]  cfg_wdata_i

    , output logic [sacc_msg_pkg::data_width-1:0]  tlv_type_o
    , output logic [sacc_msg_pkg::data_width-1:0]  tlv_idx_o
   );

   import sacc_msg_pkg::*;

   logic [data_width-1:0] tlv_type_q;
   logic [data_width-1:0] tlv_idx_q;

   // wsel low picks tlv type, high picks tlv index
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         tlv_type_q <= '0;
         tlv_idx_q  <= '0;
      end
      else if (cfg_we_i)
      begin
         if (cfg_wsel_i)
         begin
            tlv_idx_q <= cfg_wdata_i;
         end
         else
         begin
            tlv_type_q <= cfg_wdata_i;
         end
      end
   end

   assign tlv_type_o = tlv_type_q;
   assign tlv_idx_o  = tlv_idx_q;

endmodule

// File: design/sacc_io_bridge.sv
// io command bridge
`timescale 1ns/10ps

module sacc_io_bridge
   (
      input  logic                                  clk_i
    , input  logic                                  arst_n_i

      // io command in
    , input  logic                                  cmd_v_i
    , input  sacc_msg_pkg::mem_type_e               cmd_type_i
    , input  logic [sacc_addr_pkg::addr_width-1:0]  cmd_addr_i
    , input  logic [sacc_msg_pkg::size_width-1:0]   cmd_size_i
    , input  logic [sacc_msg_pkg::data_width-1:0]   cmd_data_i
    , output logic                                  cmd_ready_o

      // io response out
    , output logic                                  resp_v_o
    , input  logic                                  resp_yumi_i
    , output sacc_msg_pkg::mem_type_e               resp_type_o
    , output logic [sacc_addr_pkg::addr_width-1:0]  resp_addr_o
    , output logic [sacc_msg_pkg::size_width-1:0]   resp_size_o
    , output logic [sacc_msg_pkg::data_width-1:0]   resp_data_o

      // dma fetch request out
    , output logic                                  dma_v_o
    , input  logic                                  dma_yumi_i
    , output logic [sacc_addr_pkg::addr_width-1:0]  dma_addr_o

      // register block
    , input  logic [sacc_msg_pkg::data_width-1:0]   tlv_type_i
    , input  logic [sacc_msg_pkg::data_width-1:0]   tlv_idx_i
    , output logic                                  cfg_we_o
    , output logic                                  cfg_wsel_o
    , output logic [sacc_msg_pkg::data_width-1:0]   cfg_wdata_o

      // beats to the frame engine
    , output logic                                  beat_v_o
    , output logic [sacc_msg_pkg::data_width-1:0]   beat_data_o
    , output logic [sacc_addr_pkg::tid_width-1:0]   beat_tid_o
    , output logic                                  beat_last_o
   );

   import sacc_addr_pkg::*;
   import sacc_msg_pkg::*;

   sacc_addr_u            cmd_addr;
   logic                  cmd_acc;
   logic                  is_stream;
   logic                  is_cfg;
   logic                  is_dma;
   logic                  tlv_is_last;
   logic [data_width-1:0] rd_data;

   assign cmd_addr = cmd_addr_i;

   // one transaction in flight at a time
   assign cmd_ready_o = ~resp_v_o & ~dma_v_o;
   assign cmd_acc     = cmd_v_i & cmd_ready_o;

   // classify by region first, then device number
   assign is_stream = (cmd_addr.dev_view.region != '0);
   assign is_cfg    = ~is_stream & (cmd_addr.dev_view.dev == dev_cfg);
   assign is_dma    = ~is_stream & (cmd_addr.dev_view.dev == dev_dma);

   // register writes land on the accept edge
   assign cfg_we_o    = cmd_acc & is_cfg & (cmd_type_i == mem_wr)
                      & ((cmd_addr.dev_view.reg_off == reg_tlv_type)
                      | (cmd_addr.dev_view.reg_off == reg_tlv_idx));
   assign cfg_wsel_o  = (cmd_addr.dev_view.reg_off == reg_tlv_idx);
   assign cfg_wdata_o = cmd_data_i;

   // readback is zero for writes and other offsets
   always_comb
   begin
      rd_data = '0;
      if (is_cfg && (cmd_type_i == mem_rd))
      begin
         case (cmd_addr.dev_view.reg_off)
            reg_tlv_type : rd_data = tlv_type_i;
            reg_tlv_idx  : rd_data = tlv_idx_i;
            default      : rd_data = '0;
         endcase
      end
   end

   assign tlv_is_last = (tlv_type_i == data_width'(tlv_last_type))
                      & (tlv_idx_i == data_width'(tlv_last_idx));

   // every accepted command but a dma request gets a response
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         resp_v_o <= 1'b0;
         dma_v_o  <= 1'b0;
         beat_v_o <= 1'b0;
      end
      else
      begin
         beat_v_o <= cmd_acc & is_stream;
         if (cmd_acc & ~is_dma)
         begin
            resp_v_o <= 1'b1;
         end
         else if (resp_yumi_i)
         begin
            resp_v_o <= 1'b0;
         end
         if (cmd_acc & is_dma)
         begin
            dma_v_o <= 1'b1;
         end
         else if (dma_yumi_i)
         begin
            dma_v_o <= 1'b0;
         end
      end
   end

   // payloads held until the next accept
   always_ff @(posedge clk_i)
   begin
      if (cmd_acc & ~is_dma)
      begin
         resp_type_o <= cmd_type_i;
         resp_addr_o <= cmd_addr_i;
         resp_size_o <= cmd_size_i;
         resp_data_o <= rd_data;
      end
      if (cmd_acc & is_dma)
      begin
         dma_addr_o <= cmd_data_i[addr_width-1:0];
      end
      if (cmd_acc & is_stream)
      begin
         beat_data_o <= cmd_data_i;
         beat_tid_o  <= cmd_addr.stream_view.beat_tid;
         beat_last_o <= tlv_is_last;
      end
   end

endmodule

// File: design/sacc_frame_engine.sv
// frame sum engine
`timescale 1ns/10ps

module sacc_frame_engine
   (
      input  logic                                 clk_i
    , input  logic                                 arst_n_i

    , input  logic                                 beat_v_i
    , input  logic [sacc_msg_pkg::data_width-1:0]  beat_data_i
    , input  logic [sacc_addr_pkg::tid_width-1:0]  beat_tid_i
    , input  logic                                 beat_last_i

    , output logic                                 frame_sum_v_o
    , output logic [sacc_msg_pkg::data_width-1:0]  frame_sum_o
    , output logic [sacc_addr_pkg::tid_width-1:0]  frame_tid_o
    , output logic                                 engine_idle_o
   );

   import sacc_msg_pkg::*;

   logic [data_width-1:0] acc_q;
   logic [data_width-1:0] acc_next;
   logic                  frame_open_q;

   // wraps at 64 bits
   assign acc_next = acc_q + beat_data_i;

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         acc_q         <= '0;
         frame_open_q  <= 1'b0;
         frame_sum_v_o <= 1'b0;
      end
      else
      begin
         frame_sum_v_o <= beat_v_i & beat_last_i;
         if (beat_v_i)
         begin
            // a last beat closes the frame and clears the sum
            acc_q        <= beat_last_i ? '0 : acc_next;
            frame_open_q <= ~beat_last_i;
         end
      end
   end

   // result fields valid with the strobe
   always_ff @(posedge clk_i)
   begin
      if (beat_v_i & beat_last_i)
      begin
         frame_sum_o <= acc_next;
         frame_tid_o <= beat_tid_i;
      end
   end

   assign engine_idle_o = ~frame_open_q;

endmodule

// File: design/sacc_top.sv
// stream accelerator top
`timescale 1ns/10ps

module sacc_top
   (
      input  logic                                  clk_i
    , input  logic                                  arst_n_i

    , input  logic                                  cmd_v_i
    , input  sacc_msg_pkg::mem_type_e               cmd_type_i
    , input  logic [sacc_addr_pkg::addr_width-1:0]  cmd_addr_i
    , input  logic [sacc_msg_pkg::size_width-1:0]   cmd_size_i
    , input  logic [sacc_msg_pkg::data_width-1:0]   cmd_data_i
    , output logic                                  cmd_ready_o

    , output logic                                  resp_v_o
    , input  logic                                  resp_yumi_i
    , output sacc_msg_pkg::mem_type_e               resp_type_o
    , output logic [sacc_addr_pkg::addr_width-1:0]  resp_addr_o
    , output logic [sacc_msg_pkg::size_width-1:0]   resp_size_o
    , output logic [sacc_msg_pkg::data_width-1:0]   resp_data_o

    , output logic                                  dma_v_o
    , input  logic                                  dma_yumi_i
    , output logic [sacc_addr_pkg::addr_width-1:0]  dma_addr_o

    , output logic                                  frame_sum_v_o
    , output logic [sacc_msg_pkg::data_width-1:0]   frame_sum_o
    , output logic [sacc_addr_pkg::tid_width-1:0]   frame_tid_o
    , output logic                                  engine_idle_o
   );

   import sacc_addr_pkg::*;
   import sacc_msg_pkg::*;

   // bridge to register block
   logic                  cfg_we;
   logic                  cfg_wsel;
   logic [data_width-1:0] cfg_wdata;
   logic [data_width-1:0] tlv_type;
   logic [data_width-1:0] tlv_idx;

   // bridge to engine
   logic                  beat_v;
   logic [data_width-1:0] beat_data;
   logic [tid_width-1:0]  beat_tid;
   logic                  beat_last;

   sacc_io_bridge i_bridge (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .cmd_v_i     (cmd_v_i),
      .cmd_type_i  (cmd_type_i),
      .cmd_addr_i  (cmd_addr_i),
      .cmd_size_i  (cmd_size_i),
      .cmd_data_i  (cmd_data_i),
      .cmd_ready_o (cmd_ready_o),
      .resp_v_o    (resp_v_o),
      .resp_yumi_i (resp_yumi_i),
      .resp_type_o (resp_type_o),
      .resp_addr_o (resp_addr_o),
      .resp_size_o (resp_size_o),
      .resp_data_o (resp_data_o),
      .dma_v_o     (dma_v_o),
      .dma_yumi_i  (dma_yumi_i),
      .dma_addr_o  (dma_addr_o),
      .tlv_type_i  (tlv_type),
      .tlv_idx_i   (tlv_idx),
      .cfg_we_o    (cfg_we),
      .cfg_wsel_o  (cfg_wsel),
      .cfg_wdata_o (cfg_wdata),
      .beat_v_o    (beat_v),
      .beat_data_o (beat_data),
      .beat_tid_o  (beat_tid),
      .beat_last_o (beat_last)
   );

   sacc_cfg_regs i_cfg_regs (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .cfg_we_i    (cfg_we),
      .cfg_wsel_i  (cfg_wsel),
      .cfg_wdata_i (cfg_wdata),
      .tlv_type_o  (tlv_type),
      .tlv_idx_o   (tlv_idx)
   );

   sacc_frame_engine i_engine (
      .clk_i         (clk_i),
      .arst_n_i      (arst_n_i),
      .beat_v_i      (beat_v),
      .beat_data_i   (beat_data),
      .beat_tid_i    (beat_tid),
      .beat_last_i   (beat_last),
      .frame_sum_v_o (frame_sum_v_o),
      .frame_sum_o   (frame_sum_o),
      .frame_tid_o   (frame_tid_o),
      .engine_idle_o (engine_idle_o)
   );

endmodule

// File: tb/tb_clk_gen.sv
// testbench clock and reset
`timescale 1ns/10ps

module tb_clk_gen
   #(
      parameter int period_ns = 8
   )
   (
      output logic clk_o
    , output logic arst_n_o
   );

   initial
   begin
      clk_o    = 1'b0;
      arst_n_o = 1'b0;
      // three rising edges under reset, release on a falling edge
      repeat (3) @(posedge clk_o);
      @(negedge clk_o);
      arst_n_o = 1'b1;
   end

   always #(period_ns / 2) clk_o = ~clk_o;

endmodule

// File: tb/tb_sacc_top.sv
// stream accelerator testbench
`timescale 1ns/10ps

module tb_sacc_top;

   import sacc_addr_pkg::*;
   import sacc_msg_pkg::*;

   logic                  clk;
   logic                  arst_n;
   logic                  cmd_v;
   mem_type_e             cmd_type;
   logic [addr_width-1:0] cmd_addr;
   logic [size_width-1:0] cmd_size;
   logic [data_width-1:0] cmd_data;
   logic                  cmd_ready;
   logic                  resp_v;
   logic                  resp_yumi;
   mem_type_e             resp_type;
   logic [addr_width-1:0] resp_addr;
   logic [size_width-1:0] resp_size;
   logic [data_width-1:0] resp_data;
   logic                  dma_v;
   logic                  dma_yumi;
   logic [addr_width-1:0] dma_addr;
   logic                  frame_sum_v;
   logic [data_width-1:0] frame_sum;
   logic [tid_width-1:0]  frame_tid;
   logic                  engine_idle;
   logic                  acc;

   // reference model updated when a command is driven
   logic [31:0]           lcg_state;
   logic [data_width-1:0] type_m;
   logic [data_width-1:0] idx_m;
   logic [data_width-1:0] run_sum;
   logic                  exp_stream;
   logic                  exp_dma;
   logic                  exp_last;
   mem_type_e             exp_resp_type;
   logic [addr_width-1:0] exp_resp_addr;
   logic [size_width-1:0] exp_resp_size;
   logic [data_width-1:0] exp_resp_data;
   logic [addr_width-1:0] exp_dma_addr;
   logic [data_width-1:0] exp_frame_sum;
   logic [tid_width-1:0]  exp_frame_tid;

   tb_clk_gen i_clk_gen (.clk_o(clk), .arst_n_o(arst_n));

   sacc_top i_dut (
      .clk_i         (clk),
      .arst_n_i      (arst_n),
      .cmd_v_i       (cmd_v),
      .cmd_type_i    (cmd_type),
      .cmd_addr_i    (cmd_addr),
      .cmd_size_i    (cmd_size),
      .cmd_data_i    (cmd_data),
      .cmd_ready_o   (cmd_ready),
      .resp_v_o      (resp_v),
      .resp_yumi_i   (resp_yumi),
      .resp_type_o   (resp_type),
      .resp_addr_o   (resp_addr),
      .resp_size_o   (resp_size),
      .resp_data_o   (resp_data),
      .dma_v_o       (dma_v),
      .dma_yumi_i    (dma_yumi),
      .dma_addr_o    (dma_addr),
      .frame_sum_v_o (frame_sum_v),
      .frame_sum_o   (frame_sum),
      .frame_tid_o   (frame_tid),
      .engine_idle_o (engine_idle)
   );

   assign acc = cmd_v & cmd_ready;

   task automatic abort_run();
      $display("SOME TESTS FAILED");
      $fatal(1);
   endtask

   task automatic report_mismatch(input string sig, input logic [63:0] exp_v,
                                  input logic [63:0] got_v);
      $display("FAIL at %0t ns: %s expected %h got %h", $time, sig, exp_v, got_v);
      abort_run();
   endtask

   task automatic report_timeout(input string what);
      $display("timeout at %0t ns: %s", $time, what);
      abort_run();
   endtask

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic logic [63:0] rand_word();
      return {next_rand(), next_rand()};
   endfunction

   function automatic logic [addr_width-1:0] dev_addr(input logic [3:0] dev,
                                                      input logic [19:0] off);
      sacc_addr_u a;
      a                  = '0;
      a.dev_view.dev     = dev;
      a.dev_view.reg_off = off;
      return a;
   endfunction

   // any non-zero region selects the stream view
   function automatic logic [addr_width-1:0] stream_addr(input logic [3:0] tid);
      sacc_addr_u a;
      a.stream_view.region   = 9'(next_rand() % 511) + 9'd1;
      a.stream_view.beat_tid = tid;
      a.stream_view.pad      = 27'(next_rand());
      return a;
   endfunction

   task automatic wait_ready();
      int n;
      n = 0;
      while (!cmd_ready)
      begin
         @(negedge clk);
         n++;
         if (n > 50)
            report_timeout("cmd_ready_o stayed low");
      end
   endtask

   task automatic send_cmd(input mem_type_e t, input logic [addr_width-1:0] addr,
                           input logic [data_width-1:0] data);
      sacc_addr_u a;
      logic       is_cfg;
      a = addr;
      wait_ready();
      exp_stream = (a.dev_view.region != '0);
      exp_dma    = !exp_stream && (a.dev_view.dev == dev_dma);
      is_cfg     = !exp_stream && (a.dev_view.dev == dev_cfg);
      exp_last   = exp_stream && (type_m == 64'd4) && (idx_m == 64'd2);
      cmd_size   = 3'(next_rand());
      if (!exp_dma)
      begin
         exp_resp_type = t;
         exp_resp_addr = addr;
         exp_resp_size = cmd_size;
         exp_resp_data = '0;
      end
      if (is_cfg && t == mem_rd && a.dev_view.reg_off == reg_tlv_type)
         exp_resp_data = type_m;
      if (is_cfg && t == mem_rd && a.dev_view.reg_off == reg_tlv_idx)
         exp_resp_data = idx_m;
      if (is_cfg && t == mem_wr && a.dev_view.reg_off == reg_tlv_type)
         type_m = data;
      if (is_cfg && t == mem_wr && a.dev_view.reg_off == reg_tlv_idx)
         idx_m = data;
      if (exp_dma)
         exp_dma_addr = data[addr_width-1:0];
      if (exp_stream)
      begin
         // wrapping sum since the last result
         run_sum = run_sum + data;
         if (exp_last)
         begin
            exp_frame_sum = run_sum;
            exp_frame_tid = a.stream_view.beat_tid;
            run_sum       = '0;
         end
      end
      cmd_v    = 1'b1;
      cmd_type = t;
      cmd_addr = addr;
      cmd_data = data;
      @(negedge clk);
      cmd_v = 1'b0;
   endtask

   // wait for the response or dma request, then yumi after a delay
   task automatic take_out(input logic is_dma, input int delay);
      int n;
      n = 0;
      while (!(is_dma ? dma_v : resp_v))
      begin
         @(negedge clk);
         n++;
         if (n > 20)
            report_timeout(is_dma ? "dma_v_o never rose" : "resp_v_o never rose");
      end
      repeat (delay) @(negedge clk);
      resp_yumi = !is_dma;
      dma_yumi  = is_dma;
      @(negedge clk);
      resp_yumi = 1'b0;
      dma_yumi  = 1'b0;
   endtask

   task automatic send_frame(input int beats);
      int n;
      send_cmd(mem_wr, dev_addr(dev_cfg, reg_tlv_type), rand_word() | 64'h100);
      take_out(1'b0, 0);
      send_cmd(mem_wr, dev_addr(dev_cfg, reg_tlv_idx), rand_word() | 64'h100);
      take_out(1'b0, 0);
      for (int i = 0; i < beats; i++)
      begin
         send_cmd(mem_wr, stream_addr(4'(next_rand())), rand_word());
         take_out(1'b0, int'(next_rand() % 3));
      end
      send_cmd(mem_wr, dev_addr(dev_cfg, reg_tlv_type), 64'd4);
      take_out(1'b0, 0);
      send_cmd(mem_wr, dev_addr(dev_cfg, reg_tlv_idx), 64'd2);
      take_out(1'b0, 0);
      send_cmd(mem_wr, stream_addr(4'(next_rand())), rand_word());
      take_out(1'b0, int'(next_rand() % 3));
      // the engine goes idle again with the result
      n = 0;
      while (!engine_idle)
      begin
         @(negedge clk);
         n++;
         if (n > 20)
            report_timeout("engine_idle_o stayed low after the last beat");
      end
   endtask

   // response and dma timing
   assert property (@(posedge clk) disable iff (!arst_n) (acc && !exp_dma) |=> resp_v)
      else report_mismatch("resp_v_o", 1, $sampled(resp_v));
   assert property (@(posedge clk) disable iff (!arst_n) (acc && exp_dma) |=> !resp_v)
      else report_mismatch("resp_v_o", 0, $sampled(resp_v));
   assert property (@(posedge clk) disable iff (!arst_n) (acc && exp_dma) |=> dma_v)
      else report_mismatch("dma_v_o", 1, $sampled(dma_v));
   assert property (@(posedge clk) disable iff (!arst_n) (resp_v && !resp_yumi) |=> resp_v)
      else report_mismatch("resp_v_o", 1, $sampled(resp_v));
   assert property (@(posedge clk) disable iff (!arst_n) (dma_v && !dma_yumi) |=> dma_v)
      else report_mismatch("dma_v_o", 1, $sampled(dma_v));
   assert property (@(posedge clk) disable iff (!arst_n) (resp_v || dma_v) |-> !cmd_ready)
      else report_mismatch("cmd_ready_o", 0, $sampled(cmd_ready));

   // held fields
   assert property (@(posedge clk) disable iff (!arst_n) resp_v |-> resp_type == exp_resp_type)
      else report_mismatch("resp_type_o", $sampled(exp_resp_type), $sampled(resp_type));
   assert property (@(posedge clk) disable iff (!arst_n) resp_v |-> resp_addr == exp_resp_addr)
      else report_mismatch("resp_addr_o", $sampled(exp_resp_addr), $sampled(resp_addr));
   assert property (@(posedge clk) disable iff (!arst_n) resp_v |-> resp_size == exp_resp_size)
      else report_mismatch("resp_size_o", $sampled(exp_resp_size), $sampled(resp_size));
   assert property (@(posedge clk) disable iff (!arst_n) resp_v |-> resp_data == exp_resp_data)
      else report_mismatch("resp_data_o", $sampled(exp_resp_data), $sampled(resp_data));
   assert property (@(posedge clk) disable iff (!arst_n) dma_v |-> dma_addr == exp_dma_addr)
      else report_mismatch("dma_addr_o", $sampled(exp_dma_addr), $sampled(dma_addr));

   // frame results two clocks after the last beat is accepted
   assert property (@(posedge clk) disable iff (!arst_n)
                    (acc && exp_stream && exp_last) |-> ##2 frame_sum_v)
      else report_mismatch("frame_sum_v_o", 1, $sampled(frame_sum_v));
   assert property (@(posedge clk) disable iff (!arst_n)
                    frame_sum_v |-> $past(acc && exp_stream && exp_last, 2))
      else report_mismatch("frame_sum_v_o", 0, 1);
   assert property (@(posedge clk) disable iff (!arst_n) frame_sum_v |-> frame_sum == exp_frame_sum)
      else report_mismatch("frame_sum_o", $sampled(exp_frame_sum), $sampled(frame_sum));
   assert property (@(posedge clk) disable iff (!arst_n) frame_sum_v |-> frame_tid == exp_frame_tid)
      else report_mismatch("frame_tid_o", $sampled(exp_frame_tid), $sampled(frame_tid));

   // idle level follows the open frame
   assert property (@(posedge clk) disable iff (!arst_n)
                    (acc && exp_stream && !exp_last) |-> ##2 !engine_idle)
      else report_mismatch("engine_idle_o", 0, $sampled(engine_idle));
   assert property (@(posedge clk) disable iff (!arst_n)
                    $fell(engine_idle) |-> $past(acc && exp_stream && !exp_last, 2))
      else report_mismatch("engine_idle_o", 1, 0);
   assert property (@(posedge clk) disable iff (!arst_n) $rose(engine_idle) |-> frame_sum_v)
      else report_mismatch("frame_sum_v_o", 1, $sampled(frame_sum_v));
   assert property (@(posedge clk) disable iff (!arst_n) frame_sum_v |-> engine_idle)
      else report_mismatch("engine_idle_o", 1, $sampled(engine_idle));

   initial
   begin
      int n;
      cmd_v         = 1'b0;
      cmd_type      = mem_rd;
      cmd_addr      = '0;
      cmd_size      = '0;
      cmd_data      = '0;
      resp_yumi     = 1'b0;
      dma_yumi      = 1'b0;
      lcg_state     = 32'h3fea_fb3b;
      type_m        = '0;
      idx_m         = '0;
      run_sum       = '0;
      exp_stream    = 1'b0;
      exp_dma       = 1'b0;
      exp_last      = 1'b0;
      exp_frame_sum = '0;
      exp_frame_tid = '0;
      n = 0;
      while (arst_n !== 1'b1)
      begin
         @(negedge clk);
         n++;
         if (n > 10)
            report_timeout("reset was never released");
      end
      @(negedge clk);
      assert (cmd_ready) else report_mismatch("cmd_ready_o", 1, cmd_ready);
      assert (engine_idle) else report_mismatch("engine_idle_o", 1, engine_idle);
      assert (!resp_v) else report_mismatch("resp_v_o", 0, resp_v);
      assert (!dma_v) else report_mismatch("dma_v_o", 0, dma_v);
      assert (!frame_sum_v) else report_mismatch("frame_sum_v_o", 0, frame_sum_v);

      // registers read zero after reset, then random write and readback
      send_cmd(mem_rd, dev_addr(dev_cfg, reg_tlv_type), rand_word());
      take_out(1'b0, 0);
      send_cmd(mem_rd, dev_addr(dev_cfg, reg_tlv_idx), rand_word());
      take_out(1'b0, 0);
      for (int i = 0; i < 4; i++)
      begin
         send_cmd(mem_wr, dev_addr(dev_cfg, reg_tlv_type), rand_word() | 64'h100);
         take_out(1'b0, int'(next_rand() % 5));
         send_cmd(mem_wr, dev_addr(dev_cfg, reg_tlv_idx), rand_word());
         take_out(1'b0, int'(next_rand() % 5));
         send_cmd(mem_rd, dev_addr(dev_cfg, reg_tlv_type), rand_word());
         take_out(1'b0, int'(next_rand() % 5));
         send_cmd(mem_rd, dev_addr(dev_cfg, reg_tlv_idx), rand_word());
         take_out(1'b0, int'(next_rand() % 5));
      end

      // dma fetch requests
      for (int i = 0; i < 3; i++)
      begin
         send_cmd(mem_wr, dev_addr(dev_dma, 20'(next_rand())), rand_word());
         take_out(1'b1, int'(next_rand() % 5));
      end

      // unknown device answers with zero
      send_cmd(mem_wr, dev_addr(4'd5, reg_tlv_type), rand_word());
      take_out(1'b0, 1);
      send_cmd(mem_rd, dev_addr(4'd5, reg_tlv_idx), rand_word());
      take_out(1'b0, 0);

      // frames of one to five beats
      for (int f = 0; f < 4; f++)
      begin
         send_frame(f + int'(next_rand() % 2));
      end

      repeat (4) @(negedge clk);
      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

// File: vlog.f
design/sacc_addr_pkg.sv
design/sacc_msg_pkg.sv
design/sacc_cfg_regs.sv
design/sacc_io_bridge.sv
design/sacc_frame_engine.sv
design/sacc_top.sv
tb/tb_clk_gen.sv
tb/tb_sacc_top.sv
